// ==== compile.f ====
logic/heapPkg.sv
logic/heapAllocator.sv
logic/heapAccessCheck.sv
logic/heapStore.sv
logic/heapMemory.sv
dv/heapChecker.sv
dv/heapTb.sv

// ==== dv/heapChecker.sv ====
//------------------------------------------------------------
// Reference model of the heap array memory. Requests are taken
// at the rising edge, responses compared at the next falling
// edge. Elements never written since start are not compared.
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module heapChecker (
  input  wire logic                clock,
  input  wire logic                resetN,
  input  wire logic                reqValid,
  input  wire heapPkg::heapReq_t   req,
  input  wire logic                respValid,
  input  wire heapPkg::heapResp_t  resp,
  output int                       errorCount,
  output int                       checkCount
);
  import heapPkg::*;

  int          freshCount;                            // Handles given out since reset
  int          freedTop;
  heapHandle_t freedStack [heapArrays];
  bit          allocFlags [heapArrays];
  int          sizes      [heapArrays];
  heapData_t   elements   [heapArrays][heapLength];
  bit          known      [heapArrays][heapLength];   // Written at least once

  logic        expectValid;
  heapData_t   expData;
  bit          expDataKnown;
  heapErr_t    expErr;
  heapOp_t     reqOp;
  time         reqTime;
  int          errors = 0;
  int          checks = 0;

  assign errorCount = errors;
  assign checkCount = checks;

  task automatic clearHeap();
    freshCount = 0;
    freedTop   = 0;
    allocFlags = '{default: 1'b0};
    sizes      = '{default: 0};
  endtask

  task automatic setData(input heapData_t value, input bit isKnown);
    expData      = value;
    expDataKnown = isKnown;
  endtask

  // Model update ----------------------------------------------
  task automatic allocateArray();
    heapHandle_t h;
    if (freedTop > 0) begin
      freedTop--;
      h = freedStack[heapHandle_t'(freedTop)];        // Last freed comes back first
    end else if (freshCount < heapArrays) begin
      h = heapHandle_t'(freshCount);
      freshCount++;
    end else begin
      expErr = errOutOfMemory;
      return;
    end
    allocFlags[h] = 1'b1;
    sizes[h]      = 0;
    setData(heapData_t'(h), 1'b1);
  endtask

  task automatic accessLiveArray(input heapReq_t r);
    heapHandle_t a;
    heapIndex_t  i;
    heapIndex_t  top;
    heapData_t   oldValue;
    heapData_t   newValue;
    a = r.array;
    i = r.index;
    case (r.op)
      opFree: begin
        freedStack[heapHandle_t'(freedTop)] = a;
        freedTop++;
        allocFlags[a] = 1'b0;
      end
      opWrite: begin
        elements[a][i] = r.value;
        known[a][i]    = 1'b1;
        if (int'(i) + 1 > sizes[a]) begin
          sizes[a] = int'(i) + 1;
        end
        setData(r.value, 1'b1);
      end
      opRead: begin
        if (int'(i) >= sizes[a]) expErr = errOutOfBounds;
        else setData(elements[a][i], known[a][i]);
      end
      opSize: setData(heapData_t'(sizes[a]), 1'b1);
      opPush: begin
        if (sizes[a] >= heapLength) begin
          expErr = errFull;
        end else begin
          top              = heapIndex_t'(sizes[a]);
          elements[a][top] = r.value;
          known[a][top]    = 1'b1;
          sizes[a]++;
          setData(r.value, 1'b1);
        end
      end
      opPop: begin
        if (sizes[a] == 0) begin
          expErr = errEmpty;
        end else begin
          sizes[a]--;
          top = heapIndex_t'(sizes[a]);
          setData(elements[a][top], known[a][top]);
        end
      end
      default: begin                                  // Add and AddAfter
        if (int'(i) >= sizes[a]) begin
          expErr = errOutOfBounds;
        end else begin
          oldValue = elements[a][i];
          newValue = heapData_t'((int'(oldValue) + int'(r.value)) % (1 << heapDataBits));
          elements[a][i] = newValue;
          setData((r.op == opAdd) ? newValue : oldValue, known[a][i]);
        end
      end
    endcase
  endtask

  task automatic applyRequest(input heapReq_t r);
    heapErr_t stateErr;
    if (int'(r.array) >= freshCount) stateErr = errNotAllocated;
    else if (!allocFlags[r.array]) stateErr = errFreed;
    else stateErr = errNone;
    expErr = errNone;
    case (r.op)
      opReset: clearHeap();                           // Data word is kept
      opAlloc: allocateArray();
      default: begin
        if (stateErr != errNone) expErr = stateErr;
        else accessLiveArray(r);
      end
    endcase
  endtask

  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      clearHeap();
      expectValid = 1'b0;
      expErr      = errNone;
      setData('0, 1'b1);
    end else begin
      expectValid = reqValid;
      if (reqValid) begin
        reqOp   = req.op;
        reqTime = $time;
        applyRequest(req);
      end
    end
  end

  // Comparison ------------------------------------------------
  always @(negedge clock) begin
    if (resetN === 1'b1) begin
      if (respValid !== expectValid) begin
        errors++;
        if (expectValid) begin
          $display("No response came for the request taken at %0t", reqTime);
        end else begin
          $display("A response came at %0t without a request before it", $time);
        end
      end else if (respValid) begin
        checks++;
        if (resp.error !== expErr) begin
          errors++;
          $display("error at %0t: %s gave error %s, expected %s", $time, reqOp.name(),
                   resp.error.name(), expErr.name());
        end
        if (expDataKnown && resp.data !== expData) begin
          errors++;
          $display("error at %0t: %s gave data 0x%03h, expected 0x%03h", $time,
                   reqOp.name(), resp.data, expData);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/heapTb.sv ====
//------------------------------------------------------------
// Testbench top for the heap array memory. Directed tests run
// first, then seeded random requests. heapChecker compares.
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module heapTb;
  import heapPkg::*;

  localparam int totalRequests = 524;                 // Requests over all six tests
  localparam int cycleLimit    = 3 * totalRequests + 100;

  logic      clock;
  logic      resetN;
  logic      reqValid;
  heapReq_t  req;
  logic      respValid;
  heapResp_t resp;
  int        errorCount;
  int        checkCount;
  int        errorsBefore;
  int        cycleCount;

  heapMemory u_dut (
    .clock     (clock),
    .resetN    (resetN),
    .reqValid  (reqValid),
    .req       (req),
    .respValid (respValid),
    .resp      (resp)
  );

  heapChecker u_checker (
    .clock      (clock),
    .resetN     (resetN),
    .reqValid   (reqValid),
    .req        (req),
    .respValid  (respValid),
    .resp       (resp),
    .errorCount (errorCount),
    .checkCount (checkCount)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Request driving -------------------------------------------
  task automatic sendReq(input heapOp_t op, input int array, input int index, input int value);
    @(posedge clock);
    #2;
    reqValid  = 1'b1;
    req.op    = op;
    req.array = heapHandle_t'(array);
    req.index = heapIndex_t'(index);
    req.value = heapData_t'(value);
  endtask

  task automatic endTest(input string name);
    @(posedge clock);
    #2;
    reqValid = 1'b0;
    repeat (2) @(posedge clock);                      // One-cycle latency plus check edge
    $display("%s: %0d errors", name, errorCount - errorsBefore);
    errorsBefore = errorCount;
  endtask

  initial begin
    void'($urandom(16));
    errorsBefore = 0;
    resetN       = 1'b0;
    reqValid     = 1'b0;
    req          = '0;
    repeat (10) @(posedge clock);
    #2;
    resetN = 1'b1;

    for (int k = 0; k <= heapArrays; k++) begin       // Last one runs out of memory
      sendReq(opAlloc, 0, 0, 0);
    end
    endTest("test 1 allocate all arrays");

    for (int k = 0; k < 24; k++) begin
      sendReq(opWrite, $urandom % 4, $urandom % heapLength, $urandom);
    end
    for (int a = 0; a < 4; a++) begin
      sendReq(opSize, a, 0, 0);
      for (int i = 0; i < heapLength; i++) begin
        sendReq(opRead, a, i, 0);
      end
    end
    endTest("test 2 write and read");

    for (int k = 0; k <= heapLength; k++) begin
      sendReq(opPush, 4, 0, $urandom);
    end
    for (int k = 0; k <= heapLength; k++) begin
      sendReq(opPop, 4, 0, 0);
    end
    endTest("test 3 push and pop");

    sendReq(opFree, 5, 0, 0);
    sendReq(opFree, 2, 0, 0);
    sendReq(opFree, 6, 0, 0);
    sendReq(opRead, 2, 0, 0);
    sendReq(opSize, 5, 0, 0);
    sendReq(opFree, 6, 0, 0);                         // Double free
    for (int k = 0; k < 3; k++) begin
      sendReq(opAlloc, 0, 0, 0);
    end
    sendReq(opReset, 0, 0, 0);
    sendReq(opSize, 0, 0, 0);
    sendReq(opAlloc, 0, 0, 0);
    sendReq(opSize, 3, 0, 0);
    endTest("test 4 free, reuse and reset");

    for (int k = 0; k < heapLength; k++) begin
      sendReq(opPush, 0, 0, $urandom);
    end
    for (int k = 0; k < 16; k++) begin
      sendReq(($urandom % 2 == 0) ? opAdd : opAddAfter, 0, $urandom % heapLength, $urandom);
    end
    endTest("test 5 add and add after");

    for (int k = 0; k < 400; k++) begin
      if ($urandom % 32 == 0) begin                   // Rare, so arrays can fill up
        sendReq(opReset, 0, 0, 0);
      end else begin
        sendReq(heapOp_t'(1 + $urandom % 9), $urandom % heapArrays, $urandom % heapLength,
                $urandom);
      end
    end
    endTest("test 6 random requests");

    $display("%0d responses checked, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Run limit -------------------------------------------------
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/heapAccessCheck.sv ====
//------------------------------------------------------------
// Size table and request checks. Each request gets exactly one
// error code. A failing request leaves all state unchanged.
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module heapAccessCheck (
  input  wire logic                  clock,
  input  wire logic                  resetN,
  input  wire logic                  reqValid,
  input  wire heapPkg::heapReq_t     req,
  input  wire logic                  arrayLive,
  input  wire heapPkg::heapErr_t     allocErr,
  input  wire heapPkg::heapHandle_t  allocHandle,
  output logic                       reqOk,
  output logic                       storeWrite,
  output heapPkg::heapIndex_t        storeIndex,
  output heapPkg::heapSize_t         sizeNow,
  output logic                       respValid,
  output heapPkg::heapErr_t          respErr
);
  import heapPkg::*;

  heapSize_t sizeTable [heapArrays];                  // Current size of each array
  heapErr_t  reqErr;
  logic      indexInside;
  logic      writesStore;

  assign sizeNow     = sizeTable[req.array];
  assign indexInside = heapSize_t'(req.index) < sizeNow;
  assign writesStore = req.op inside {opWrite, opPush, opAdd, opAddAfter};

  // Error choice ----------------------------------------------
  always_comb begin
    reqErr = errNone;
    case (req.op)
      opAlloc: reqErr = allocErr;
      opFree, opWrite, opSize: begin
        if (!arrayLive) reqErr = allocErr;
      end
      opRead, opAdd, opAddAfter: begin
        if (!arrayLive) reqErr = allocErr;
        else if (!indexInside) reqErr = errOutOfBounds;
      end
      opPush: begin
        if (!arrayLive) reqErr = allocErr;
        else if (sizeNow >= heapLength) reqErr = errFull;
      end
      opPop: begin
        if (!arrayLive) reqErr = allocErr;
        else if (sizeNow == '0) reqErr = errEmpty;
      end
      default: reqErr = errNone;                      // Reset never fails
    endcase
  end

  assign reqOk      = reqErr == errNone;
  assign storeWrite = reqValid && reqOk && writesStore;

  // Push appends past the end, Pop takes the last element
  always_comb begin
    case (req.op)
      opPush:  storeIndex = heapIndex_t'(sizeNow);
      opPop:   storeIndex = heapIndex_t'(sizeNow - 1'b1);
      default: storeIndex = req.index;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapArrays; i++) begin
        sizeTable[i] <= '0;
      end
    end else if (reqValid && reqOk) begin
      case (req.op)
        opReset: begin
          for (int i = 0; i < heapArrays; i++) begin
            sizeTable[i] <= '0;
          end
        end
        opAlloc: sizeTable[allocHandle] <= '0;        // New arrays start empty
        opWrite: begin
          if (!indexInside) sizeTable[req.array] <= heapSize_t'(req.index) + 1'b1;
        end
        opPush:  sizeTable[req.array] <= sizeNow + 1'b1;
        opPop:   sizeTable[req.array] <= sizeNow - 1'b1;
        default: ;
      endcase
    end
  end

  // Response strobe and error ---------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
      respErr   <= errNone;
    end else begin
      respValid <= reqValid;
      if (reqValid) respErr <= reqErr;                // Held between requests
    end
  end

  for (genvar g = 0; g < heapArrays; g++) begin : gSizeBound
    assert property (@(posedge clock) disable iff (!resetN) sizeTable[g] <= heapLength)
      else $error("size of array %0d beyond array length", g);
  end

  assert property (@(posedge clock) disable iff (!resetN) reqValid |=> respValid);
  assert property (@(posedge clock) disable iff (!resetN) !reqValid |=> !respValid);

endmodule

`default_nettype wire

// ==== logic/heapAllocator.sv ====
//------------------------------------------------------------
// Hands out and takes back array handles. Freed handles are
// reused last freed first, before any fresh handle is used.
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module heapAllocator (
  input  wire logic                  clock,
  input  wire logic                  resetN,
  input  wire logic                  reqValid,
  input  wire heapPkg::heapReq_t     req,
  output logic                       arrayLive,
  output heapPkg::heapHandle_t       allocHandle,
  output heapPkg::heapErr_t          allocErr
);
  import heapPkg::*;

  logic [heapAddrBits:0] freshCount;                  // Handles given out since reset
  logic [heapAddrBits:0] freedTop;                    // Depth of the freed stack
  heapHandle_t           freedStack [heapArrays];
  logic [heapArrays-1:0] allocFlags;                  // One per handle, set while in use
  logic                  neverUsed;
  logic                  allocOk;

  assign neverUsed   = {1'b0, req.array} >= freshCount;
  assign arrayLive   = !neverUsed && allocFlags[req.array];
  assign allocOk     = (freedTop != '0) || (freshCount < heapArrays);
  assign allocHandle = (freedTop != '0) ? freedStack[heapHandle_t'(freedTop - 1'b1)]
                                        : freshCount[heapAddrBits-1:0];

  // Alloc reports memory exhaustion, every other op the state of its array
  always_comb begin
    if (req.op == opAlloc) begin
      allocErr = allocOk ? errNone : errOutOfMemory;
    end else if (neverUsed) begin
      allocErr = errNotAllocated;
    end else if (!allocFlags[req.array]) begin
      allocErr = errFreed;
    end else begin
      allocErr = errNone;
    end
  end

  // Counters and flags -----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freshCount <= '0;
      freedTop   <= '0;
      allocFlags <= '0;
    end else if (reqValid) begin
      case (req.op)
        opReset: begin
          freshCount <= '0;
          freedTop   <= '0;
          allocFlags <= '0;
        end
        opAlloc: begin
          if (allocOk) begin
            if (freedTop != '0) begin
              freedTop <= freedTop - 1'b1;            // Pop a freed handle
            end else begin
              freshCount <= freshCount + 1'b1;
            end
            allocFlags[allocHandle] <= 1'b1;
          end
        end
        opFree: begin
          if (arrayLive) begin
            freedTop               <= freedTop + 1'b1;
            allocFlags[req.array]  <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid && req.op == opFree && arrayLive) begin
      freedStack[heapHandle_t'(freedTop)] <= req.array;  // Top below heapArrays here
    end
  end

  // Every freed handle was once a fresh one
  assert property (@(posedge clock) disable iff (!resetN)
    freedTop <= freshCount && freshCount <= heapArrays)
    else $error("freed stack deeper than the handles given out");

endmodule

`default_nettype wire

// ==== logic/heapMemory.sv ====
//------------------------------------------------------------
// Heap array memory top. One request per cycle at most, each
// answered one cycle later. No back-pressure.
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module heapMemory (
  input  wire logic                  clock,
  input  wire logic                  resetN,
  input  wire logic                  reqValid,
  input  wire heapPkg::heapReq_t     req,
  output logic                       respValid,
  output heapPkg::heapResp_t         resp
);
  import heapPkg::*;

  logic        arrayLive;
  heapHandle_t allocHandle;
  heapErr_t    allocErr;
  logic        reqOk;                                 // Request passes every check
  logic        storeWrite;
  heapIndex_t  storeIndex;
  heapSize_t   sizeNow;
  heapData_t   respData;
  heapErr_t    respErr;

  heapAllocator u_allocator (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .req         (req),
    .arrayLive   (arrayLive),
    .allocHandle (allocHandle),
    .allocErr    (allocErr)
  );

  heapAccessCheck u_accessCheck (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .req         (req),
    .arrayLive   (arrayLive),
    .allocErr    (allocErr),
    .allocHandle (allocHandle),
    .reqOk       (reqOk),
    .storeWrite  (storeWrite),
    .storeIndex  (storeIndex),
    .sizeNow     (sizeNow),
    .respValid   (respValid),
    .respErr     (respErr)
  );

  heapStore u_store (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .req         (req),
    .reqOk       (reqOk),
    .storeWrite  (storeWrite),
    .storeIndex  (storeIndex),
    .sizeNow     (sizeNow),
    .allocHandle (allocHandle),
    .respData    (respData)
  );

  assign resp = '{data: respData, error: respErr};

endmodule

`default_nettype wire

// ==== logic/heapPkg.sv ====
//------------------------------------------------------------
// Sizes, opcodes, error codes and the request and response
// words of the heap array memory. Array length and array count
// are powers of two given by the index and handle widths.
//------------------------------------------------------------
`default_nettype none

package heapPkg;

  // Sizes -----------------------------------------------------
  localparam int heapAddrBits  = 3;                   // Bits in an array handle
  localparam int heapIndexBits = 3;                   // Bits in an element index
  localparam int heapDataBits  = 12;                  // Bits in an element
  localparam int heapArrays    = 2 ** heapAddrBits;   // Arrays in the heap
  localparam int heapLength    = 2 ** heapIndexBits;  // Elements per array
  localparam int heapSizeBits  = heapIndexBits + 1;   // Holds 0 up to heapLength

  typedef logic [heapAddrBits-1:0]  heapHandle_t;
  typedef logic [heapIndexBits-1:0] heapIndex_t;
  typedef logic [heapDataBits-1:0]  heapData_t;
  typedef logic [heapSizeBits-1:0]  heapSize_t;

  // Opcodes and error codes -----------------------------------
  typedef enum logic [3:0] {
    opReset    = 4'd0,                                // Drop every array
    opAlloc    = 4'd1,                                // Reuses freed arrays first
    opFree     = 4'd2,
    opWrite    = 4'd3,                                // Grows the size if needed
    opRead     = 4'd4,
    opSize     = 4'd5,
    opPush     = 4'd6,
    opPop      = 4'd7,
    opAdd      = 4'd8,                                // Returns the new value
    opAddAfter = 4'd9                                 // Returns the old value
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Handle never given out
    errFreed        = 3'd2,
    errOutOfBounds  = 3'd3,                           // Index at or past the size
    errFull         = 3'd4,
    errEmpty        = 3'd5,
    errOutOfMemory  = 3'd6                            // No fresh or freed array left
  } heapErr_t;

  // Request and response words --------------------------------
  typedef struct packed {
    heapOp_t     op;
    heapHandle_t array;
    heapIndex_t  index;
    heapData_t   value;
  } heapReq_t;

  typedef struct packed {
    heapData_t data;
    heapErr_t  error;
  } heapResp_t;

endpackage

`default_nettype wire

// ==== logic/heapStore.sv ====
//------------------------------------------------------------
// Element storage, adder and response data register. Sums wrap
// at the element width. Free and Reset leave the data word.
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module heapStore (
  input  wire logic                  clock,
  input  wire logic                  resetN,
  input  wire logic                  reqValid,
  input  wire heapPkg::heapReq_t     req,
  input  wire logic                  reqOk,
  input  wire logic                  storeWrite,
  input  wire heapPkg::heapIndex_t   storeIndex,
  input  wire heapPkg::heapSize_t    sizeNow,
  input  wire heapPkg::heapHandle_t  allocHandle,
  output heapPkg::heapData_t         respData
);
  import heapPkg::*;

  heapData_t elements [heapArrays][heapLength];       // One fixed block per array
  heapData_t oldValue;                                // Element before this request
  heapData_t sumValue;
  heapData_t newValue;                                // Element after this request

  assign oldValue = elements[req.array][storeIndex];
  assign sumValue = oldValue + req.value;
  assign newValue = (req.op inside {opAdd, opAddAfter}) ? sumValue : req.value;

  // Element memory ---------------------------------------------
  always_ff @(posedge clock) begin
    if (storeWrite) begin
      elements[req.array][storeIndex] <= newValue;
    end
  end

  // Response data, kept as is on a failing request
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respData <= '0;
    end else if (reqValid && reqOk) begin
      case (req.op)
        opAlloc:                   respData <= heapData_t'(allocHandle);
        opSize:                    respData <= heapData_t'(sizeNow);
        opWrite, opPush, opAdd:    respData <= newValue;
        opRead, opPop, opAddAfter: respData <= oldValue;
        default: ;
      endcase
    end
  end

  // Write enable comes from the checker, so tie it to a writing op here
  assert property (@(posedge clock) disable iff (!resetN)
    storeWrite |-> reqValid && reqOk
                   && (req.op inside {opWrite, opPush, opAdd, opAddAfter}))
    else $error("element write without a writing request");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the heap memory testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module heapTb -o heapSim \
  && ./obj_dir/heapSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
